// ==== src/fe_pkg.sv ====
package fe_pkg;

  // ------------------------------------------------------------------
  // Front end sizing
  // ------------------------------------------------------------------

  // Instructions per aligned fetch packet.
  localparam int fetch_width = 4;

  // Issue slots per cycle.
  localparam int issue_width = 2;

  // Instruction buffer geometry.
  localparam int ib_depth = 16;
  localparam int ib_ptr_w = 4;
  localparam int ib_cnt_w = 5;

  // ------------------------------------------------------------------
  // Bundles
  // ------------------------------------------------------------------

  // One buffered instruction with its address.
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
  } fe_entry_t;

  // Aligned fetch packet with word 0 at the lowest address.
  typedef struct packed {
    logic                             valid;
    logic [31:0]                      base_pc;
    logic [1:0]                       offset;
    logic [fetch_width-1:0][31:0]     words;
  } fetch_pkt_t;

  // Packer output with entries compacted from lane 0.
  typedef struct packed {
    logic [2:0]                       num;
    fe_entry_t [fetch_width-1:0]      entries;
  } push_bus_t;

  typedef struct packed {
    logic      valid;
    fe_entry_t entry;
  } issue_slot_t;

endpackage

// ==== src/fetch_packer.sv ====
`timescale 1ns/1ns

module fetch_packer (
  input  logic               clk,
  input  logic               rst_n,
  input  fe_pkg::fetch_pkt_t fetch,
  input  logic               fetch_ready,
  input  logic               flush,
  output fe_pkg::push_bus_t  push
);

  logic       accept;
  logic [2:0] src_idx [fe_pkg::fetch_width];

  // A packet is taken only when the buffer has room and no flush is pending.
  assign accept = fetch.valid && fetch_ready && !flush;

  // ------------------------------------------------------------------
  // Lane to word mapping
  // ------------------------------------------------------------------

  // Lane i carries word offset+i.
  always_comb begin
    for (int i = 0; i < fe_pkg::fetch_width; i++) begin
      src_idx[i] = {1'b0, fetch.offset} + 3'(i);
    end
  end

  // ------------------------------------------------------------------
  // Push bus
  // ------------------------------------------------------------------

  always_comb begin
    push = '0;
    if (accept) begin
      push.num = 3'(fe_pkg::fetch_width) - {1'b0, fetch.offset};
    end
    for (int i = 0; i < fe_pkg::fetch_width; i++) begin
      // Lanes past the end of the packet stay zero.
      if (accept && src_idx[i] < 3'(fe_pkg::fetch_width)) begin
        push.entries[i].instr = fetch.words[src_idx[i][1:0]];
        push.entries[i].pc    = fetch.base_pc + {27'd0, src_idx[i], 2'b00};
      end
    end
  end

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  // Fetch hands over 16-byte aligned packets only.
  a_base_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    fetch.valid |-> (fetch.base_pc[3:0] == 4'h0)
  ) else $error("fetch base_pc not 16-byte aligned");

endmodule

// ==== src/instr_buffer.sv ====
`timescale 1ns/1ns

module instr_buffer #(
  parameter type entry_t = fe_pkg::fe_entry_t
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                flush,
  input  logic [2:0]                          push_num,
  input  entry_t [fe_pkg::fetch_width-1:0]    push_data,
  input  logic [1:0]                          pop_num,
  output entry_t                              head0,
  output entry_t                              head1,
  output logic [fe_pkg::ib_cnt_w-1:0]         count,
  output logic                                space_for_packet
);

  typedef logic [fe_pkg::ib_ptr_w-1:0] ptr_t;
  typedef logic [fe_pkg::ib_cnt_w-1:0] cnt_t;

  entry_t mem [fe_pkg::ib_depth];

  ptr_t head_ptr;
  ptr_t tail_ptr;
  ptr_t head_nxt;
  cnt_t count_q;
  ptr_t wr_ptr [fe_pkg::fetch_width];

  // ------------------------------------------------------------------
  // Write side
  // ------------------------------------------------------------------

  // Slot addresses wrap with the pointer width.
  always_comb begin
    for (int i = 0; i < fe_pkg::fetch_width; i++) begin
      wr_ptr[i] = tail_ptr + ptr_t'(i);
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < fe_pkg::fetch_width; i++) begin
      if (i < push_num) begin
        mem[wr_ptr[i]] <= push_data[i];
      end
    end
  end

  // ------------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count_q  <= '0;
    end else if (flush) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count_q  <= '0;
    end else begin
      tail_ptr <= tail_ptr + ptr_t'(push_num);
      head_ptr <= head_ptr + ptr_t'(pop_num);
      // Pushes and pops land in the same update.
      count_q  <= count_q + cnt_t'(push_num) - cnt_t'(pop_num);
    end
  end

  // ------------------------------------------------------------------
  // Read side
  // ------------------------------------------------------------------

  assign head_nxt = head_ptr + ptr_t'(1);
  assign head0    = mem[head_ptr];
  assign head1    = mem[head_nxt];
  assign count    = count_q;

  // Room for a whole packet at 12 entries or fewer.
  assign space_for_packet =
    (count_q <= cnt_t'(fe_pkg::ib_depth - fe_pkg::fetch_width));

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  a_count_bound: assert property (
    @(posedge clk) disable iff (!rst_n)
    count_q <= fe_pkg::ib_depth
  ) else $error("buffer count above depth");

  // The selector must never pop entries that are not there.
  a_pop_le_count: assert property (
    @(posedge clk) disable iff (!rst_n)
    pop_num <= count_q
  ) else $error("pop beyond buffer occupancy");

  a_push_le_four: assert property (
    @(posedge clk) disable iff (!rst_n)
    push_num <= 3'd4
  ) else $error("push count above packet width");

  // The packer only pushes into guaranteed space.
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    (push_num != 3'd0) |-> (count_q + push_num <= fe_pkg::ib_depth)
  ) else $error("push overflows buffer");

endmodule

// ==== src/issue_select.sv ====
`timescale 1ns/1ns

module issue_select (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         flush,
  input  fe_pkg::fe_entry_t            head0,
  input  fe_pkg::fe_entry_t            head1,
  input  logic [fe_pkg::ib_cnt_w-1:0]  count,
  input  logic                         issue_ready,
  output logic [1:0]                   pop_num,
  output fe_pkg::issue_slot_t          issue0,
  output fe_pkg::issue_slot_t          issue1
);

  logic [4:0]        rd0;
  logic [4:0]        rs1_1;
  logic [4:0]        rs2_1;
  logic              raw_hazard;
  logic              valid0_q;
  logic              valid1_q;
  fe_pkg::fe_entry_t entry0_q;
  fe_pkg::fe_entry_t entry1_q;

  // ------------------------------------------------------------------
  // Pairing rule
  // ------------------------------------------------------------------

  assign rd0   = head0.instr[11:7];
  assign rs1_1 = head1.instr[19:15];
  assign rs2_1 = head1.instr[24:20];

  // x0 is never a real dependency.
  assign raw_hazard = (rd0 != 5'd0) && ((rd0 == rs1_1) || (rd0 == rs2_1));

  always_comb begin
    pop_num = 2'd0;
    if (issue_ready) begin
      if (count >= fe_pkg::issue_width && !raw_hazard) begin
        pop_num = 2'd2;
      end else if (count != '0) begin
        pop_num = 2'd1;
      end
    end
  end

  // ------------------------------------------------------------------
  // Issue registers
  // ------------------------------------------------------------------

  // Valids only move while downstream is taking slots.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid0_q <= 1'b0;
      valid1_q <= 1'b0;
    end else if (flush) begin
      valid0_q <= 1'b0;
      valid1_q <= 1'b0;
    end else if (issue_ready) begin
      valid0_q <= (pop_num != 2'd0);
      valid1_q <= (pop_num == 2'd2);
    end
  end

  always_ff @(posedge clk) begin
    if (pop_num != 2'd0) begin
      entry0_q <= head0;
    end
    if (pop_num == 2'd2) begin
      entry1_q <= head1;
    end
  end

  assign issue0 = '{valid: valid0_q, entry: entry0_q};
  assign issue1 = '{valid: valid1_q, entry: entry1_q};

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  a_slot1_needs_slot0: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(issue1.valid) |-> issue0.valid
  ) else $error("issue1 valid without issue0");

endmodule

// ==== src/frontend_top.sv ====
`timescale 1ns/1ns

module frontend_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                flush,
  input  fe_pkg::fetch_pkt_t  fetch,
  output logic                fetch_ready,
  input  logic                issue_ready,
  output fe_pkg::issue_slot_t issue0,
  output fe_pkg::issue_slot_t issue1
);

  fe_pkg::push_bus_t           push;
  fe_pkg::fe_entry_t           head0;
  fe_pkg::fe_entry_t           head1;
  logic [fe_pkg::ib_cnt_w-1:0] count;
  logic [1:0]                  pop_num;

  fetch_packer u_packer (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch       (fetch),
    .fetch_ready (fetch_ready),
    .flush       (flush),
    .push        (push)
  );

  instr_buffer #(
    .entry_t (fe_pkg::fe_entry_t)
  ) u_buffer (
    .clk              (clk),
    .rst_n            (rst_n),
    .flush            (flush),
    .push_num         (push.num),
    .push_data        (push.entries),
    .pop_num          (pop_num),
    .head0            (head0),
    .head1            (head1),
    .count            (count),
    .space_for_packet (fetch_ready)
  );

  issue_select u_issue (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .head0       (head0),
    .head1       (head1),
    .count       (count),
    .issue_ready (issue_ready),
    .pop_num     (pop_num),
    .issue0      (issue0),
    .issue1      (issue1)
  );

endmodule

// ==== testbench/tb_frontend.sv ====
`timescale 1ns/1ns

module tb_frontend;

  localparam int max_rec    = 64;
  localparam int clk_half   = 10;
  localparam int rst_cycles = 16;

  logic                clk;
  logic                rst_n;
  logic                flush;
  logic                issue_ready;
  logic                fetch_ready;
  fe_pkg::fetch_pkt_t  fetch;
  fe_pkg::issue_slot_t issue0;
  fe_pkg::issue_slot_t issue1;

  // Golden file contents.
  logic [167:0]        raw [max_rec];
  fe_pkg::fetch_pkt_t  pkt_rec [max_rec];
  int                  pkt_kind [max_rec];
  logic                mask_bits [max_rec];
  fe_pkg::fe_entry_t   exp_stream [max_rec];
  int n_pkt = 0;
  int n_mask = 0;
  int n_exp = 0;

  // Occupancy and slot model.
  fe_pkg::fe_entry_t   mq [$];
  fe_pkg::issue_slot_t m_slot0;
  fe_pkg::issue_slot_t m_slot1;
  fe_pkg::fetch_pkt_t  idle_pkt;
  int exp_idx = 0;
  int feed_idx = 0;
  int cyc = 0;
  int value_errors = 0;
  int other_errors = 0;
  logic [31:0] lfsr = 32'h00d27d37;

  frontend_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .fetch       (fetch),
    .fetch_ready (fetch_ready),
    .issue_ready (issue_ready),
    .issue0      (issue0),
    .issue1      (issue1)
  );

  always #clk_half clk = ~clk;

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Second one reads the first one's destination.
  function automatic logic raw_dep(input fe_pkg::fe_entry_t a, input fe_pkg::fe_entry_t b);
    logic [4:0] rd;
    rd = a.instr[11:7];
    return (rd != 5'd0) && (rd == b.instr[19:15] || rd == b.instr[24:20]);
  endfunction

  function automatic logic model_ready();
    return mq.size() <= fe_pkg::ib_depth - fe_pkg::fetch_width;
  endfunction

  task automatic check_slot(input fe_pkg::issue_slot_t obs, input fe_pkg::fe_entry_t exp);
    if (!obs.valid || obs.entry !== exp) begin
      value_errors++;
      $display("Fail %0t: slot pc %h instr %h, expected pc %h instr %h",
               $time, obs.entry.pc, obs.entry.instr, exp.pc, exp.instr);
    end
  endtask

  task automatic check_pair(input fe_pkg::issue_slot_t s0, input fe_pkg::issue_slot_t s1,
                            input logic exp0, input logic exp1);
    if (s0.valid !== exp0 || s1.valid !== exp1) begin
      value_errors++;
      $display("Fail %0t: issue valids %b%b, expected %b%b",
               $time, s0.valid, s1.valid, exp0, exp1);
    end
  endtask

  task automatic check_ready(input logic obs, input logic exp);
    if (obs !== exp) begin
      value_errors++;
      $display("Fail %0t: fetch_ready %b, expected %b", $time, obs, exp);
    end
  endtask

  task automatic consume(input fe_pkg::issue_slot_t s);
    if (exp_idx >= n_exp) begin
      other_errors++;
      $display("Instruction at pc %h was issued after the expected stream ended", s.entry.pc);
    end else begin
      check_slot(s, exp_stream[exp_idx]);
      exp_idx++;
    end
  endtask

  // Checks the last edge, drives the next one and advances the model.
  // Mode 0 follows the stall mask, 1 holds issue_ready low, 2 holds it high.
  task automatic step(input fe_pkg::fetch_pkt_t pkt, input logic fl, input int mode,
                      input logic doomed);
    logic rdy;
    logic acc;
    int pop;
    int w;
    fe_pkg::fe_entry_t e;
    @(negedge clk);
    check_pair(issue0, issue1, m_slot0.valid, m_slot1.valid);
    check_ready(fetch_ready, model_ready());
    case (mode)
      1: rdy = 1'b0;
      2: rdy = 1'b1;
      default: rdy = mask_bits[cyc % n_mask];
    endcase
    fetch       = pkt;
    flush       = fl;
    issue_ready = rdy;
    if (rdy && !fl) begin
      if (issue0.valid) consume(issue0);
      if (issue1.valid) consume(issue1);
    end
    acc = pkt.valid && model_ready() && !fl;
    if (fl) begin
      mq.delete();
      m_slot0.valid = 1'b0;
      m_slot1.valid = 1'b0;
    end else begin
      if (rdy) begin
        pop = 0;
        if (mq.size() >= 2 && !raw_dep(mq[0], mq[1])) pop = 2;
        else if (mq.size() >= 1) pop = 1;
        m_slot0.valid = (pop != 0);
        m_slot1.valid = (pop == 2);
        if (pop != 0) m_slot0.entry = mq.pop_front();
        if (pop == 2) m_slot1.entry = mq.pop_front();
      end
      for (w = pkt.offset; acc && w < fe_pkg::fetch_width; w++) begin
        e.pc    = pkt.base_pc + 32'(4 * w);
        e.instr = pkt.words[w];
        if (doomed) begin
          mq.push_back(e);
        end else if (feed_idx < n_exp) begin
          mq.push_back(exp_stream[feed_idx]);
          feed_idx++;
        end else begin
          other_errors++;
          $display("Golden stream is shorter than the packets that were fed");
        end
      end
    end
    cyc++;
  endtask

  task automatic send(input fe_pkg::fetch_pkt_t pkt, input int mode, input logic doomed);
    while (!model_ready()) step(idle_pkt, 1'b0, mode, 1'b0);
    step(pkt, 1'b0, mode, doomed);
  endtask

  task automatic drain();
    while (mq.size() != 0 || m_slot0.valid) step(idle_pkt, 1'b0, 0, 1'b0);
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------

  initial begin
    int i;
    int b;
    int gap;
    clk         = 1'b0;
    rst_n       = 1'b0;
    flush       = 1'b0;
    issue_ready = 1'b0;
    fetch       = '0;
    idle_pkt    = '0;
    m_slot0     = '0;
    m_slot1     = '0;
    for (i = 0; i < max_rec; i++) raw[i] = '0;
    $readmemh("testbench/frontend_golden.txt", raw);
    for (i = 0; i < max_rec && raw[i][3:0] != 4'h0; i++) begin
      case (raw[i][3:0])
        4'h9: begin
          for (b = 0; b < 32; b++) begin
            mask_bits[n_mask] = raw[i][4 + b];
            n_mask++;
          end
        end
        4'h8: begin
          exp_stream[n_exp] = '{pc: raw[i][67:36], instr: raw[i][35:4]};
          n_exp++;
        end
        default: begin
          pkt_kind[n_pkt]        = int'(raw[i][3:0]);
          pkt_rec[n_pkt].valid   = 1'b1;
          pkt_rec[n_pkt].offset  = raw[i][5:4];
          pkt_rec[n_pkt].base_pc = raw[i][39:8];
          for (b = 0; b < fe_pkg::fetch_width; b++) begin
            pkt_rec[n_pkt].words[b] = raw[i][40 + 32 * b +: 32];
          end
          n_pkt++;
        end
      endcase
    end
    if (n_pkt == 0 || n_mask == 0 || n_exp == 0) begin
      other_errors++;
      $display("Golden file is missing packets, stall mask or expected stream");
    end

    repeat (rst_cycles) @(negedge clk);
    rst_n = 1'b1;

    for (i = 0; i < n_pkt; i++) begin
      if (pkt_kind[i] == 3) begin
        // Park a packet in the slots and buffer, then flush it away.
        drain();
        send(pkt_rec[i], 1, 1'b1);
        step(idle_pkt, 1'b0, 2, 1'b0);
        step(idle_pkt, 1'b1, 1, 1'b0);
        step(idle_pkt, 1'b0, 0, 1'b0);
      end else if (pkt_kind[i] == 2) begin
        send(pkt_rec[i], 1, 1'b0);
      end else begin
        send(pkt_rec[i], 0, 1'b0);
        lfsr = lfsr_next(lfsr);
        gap  = lfsr[0];
        lfsr = lfsr_next(lfsr);
        gap  = gap + 2 * lfsr[0];
        repeat (gap) step(idle_pkt, 1'b0, 0, 1'b0);
      end
    end
    drain();
    step(idle_pkt, 1'b0, 0, 1'b0);

    if (exp_idx != n_exp) begin
      other_errors++;
      $display("Only %0d of %0d expected instructions were issued", exp_idx, n_exp);
    end
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    longint limit_ns;
    wait (n_pkt != 0);
    limit_ns = longint'(rst_cycles + 20 * n_pkt) * 2 * clk_half;
    #(limit_ns);
    $display("Run timed out after %0d ns before all packets were issued", limit_ns);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== build.f ====
src/fe_pkg.sv
src/fetch_packer.sv
src/instr_buffer.sv
src/issue_select.sv
src/frontend_top.sv
testbench/tb_frontend.sv

// ==== Bender.yml ====
package:
  name: frontend

sources:
  # RTL, package first.
  - files:
      - src/fe_pkg.sv
      - src/fetch_packer.sv
      - src/instr_buffer.sv
      - src/issue_select.sv
      - src/frontend_top.sv

  # Testbench.
  - target: test
    files:
      - testbench/tb_frontend.sv

// ==== testbench/frontend_golden.txt ====
// Records, tag in the low hex digit. 9: stall mask, bit n is issue_ready of cycle n.
// 1/2/3: w3_w2_w1_w0_basepc_offset_tag (2 feeds with issue_ready low, 3 is flushed).
// 8: expected issue stream as pc_word_tag, in program order.
f3b76def_9
7edbb9f7_9
00668633_00838333_00508233_003100b3_00001000_0_1
003100b3_000005b3_00a48033_bad00001_00001010_1_1
00838333_00508233_bad00003_bad00002_00001020_2_1
00000013_bad00006_bad00005_bad00004_00001030_3_1
bad0000d_bad0000c_bad0000b_bad0000a_00002000_0_3
00668633_00838333_00508233_003100b3_00001040_0_2
003100b3_00838333_000005b3_00a48033_00001050_0_2
003100b3_00000013_00668633_00508233_00001060_0_2
00000013_00668633_00838333_00508233_00001070_0_2
00001000_003100b3_8
00001004_00508233_8
00001008_00838333_8
0000100c_00668633_8
00001014_00a48033_8
00001018_000005b3_8
0000101c_003100b3_8
00001028_00508233_8
0000102c_00838333_8
0000103c_00000013_8
00001040_003100b3_8
00001044_00508233_8
00001048_00838333_8
0000104c_00668633_8
00001050_00a48033_8
00001054_000005b3_8
00001058_00838333_8
0000105c_003100b3_8
00001060_00508233_8
00001064_00668633_8
00001068_00000013_8
0000106c_003100b3_8
00001070_00508233_8
00001074_00838333_8
00001078_00668633_8
0000107c_00000013_8
